/* design/cop_pkg.sv */
// Shared types for the 24 MHz glue around the protection MCU.
// Every design block that carries ports or flags imports this package.

package cop_pkg;

    // Mailbox word between main CPU and MCU
    localparam int MCU_WORD_W = 16;

    // One 8051-style port
    localparam int MCU_PORT_W = 8;

    // Select lines decoded by the main CPU address map
    localparam int MCU_SEL_W = 6;

    // MCU port outputs as seen by the glue
    typedef struct packed {
        logic [MCU_PORT_W-1:0] p0;
        logic [MCU_PORT_W-1:0] p1;
        logic [MCU_PORT_W-1:0] p2;
        logic [MCU_PORT_W-1:0] p3;
    } mcu_ports_t;

    // One main CPU bus cycle toward the MCU
    typedef struct packed {
        logic [MCU_SEL_W-1:0]  sel;
        logic                  we;
        logic [MCU_WORD_W-1:0] data;
    } main_wr_t;

    // Bank flags for the memory side
    // Order matches p1[6:0] for the first four fields
    typedef struct packed {
        logic [1:0] sndflag;
        logic [1:0] b1flg;
        logic       b0flg;
        logic [1:0] mixflg;
        logic [2:0] crback;
    } bank_flags_t;

    // Transfer opcode from the active-low strobes on p2[7:4]
    typedef enum logic [2:0] {
        XFER_NONE,
        XFER_RD_HI,
        XFER_RD_LO,
        XFER_WR_HI,
        XFER_WR_LO
    } mcu_xfer_e;

    // Mail interrupt towards the MCU INT1 pin
    typedef enum logic {
        IRQ_IDLE,
        IRQ_PENDING
    } irq_state_e;

endpackage

/* design/cop_cen24.sv */
// Clock enables derived from the 24 MHz clock.
// cen3 and cen1p5 feed the sound chips, cen_mcu paces the MCU core.

`timescale 1ns/10ps

module cop_cen24 #(
    parameter int MCU_DIV = 3
) (
    input  logic clk24,
    input  logic rst24,
    output logic cen3,
    output logic cen1p5,
    output logic cen_mcu
);

    localparam int MCU_CW = (MCU_DIV > 2) ? $clog2(MCU_DIV) : 1;
    localparam logic [MCU_CW-1:0] MCU_END = MCU_CW'(MCU_DIV - 1);

    logic [3:0]        cnt16;
    logic [MCU_CW-1:0] mcu_cnt;

    // Free-running divider for the sound enables
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            cnt16 <= '0;
        end else begin
            cnt16 <= cnt16 + 4'd1;
        end
    end

    // Modulo counter for the MCU enable
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            mcu_cnt <= '0;
        end else if (mcu_cnt == MCU_END) begin
            mcu_cnt <= '0;
        end else begin
            mcu_cnt <= mcu_cnt + 1'b1;
        end
    end

    // 24/8 = 3 MHz and 24/16 = 1.5 MHz
    assign cen3    = (cnt16[2:0] == 3'b111);
    assign cen1p5  = (cnt16 == 4'hf);
    assign cen_mcu = (mcu_cnt == MCU_END);

    // A divider of one would hold cen_mcu high all the time
    a_mcu_div_min: assert property (
        @(posedge clk24) disable iff (rst24)
        MCU_DIV >= 2
    ) else $error("cop_cen24: MCU_DIV must be at least 2");

endmodule

/* design/cop_main_port.sv */
// Main CPU side of the MCU mailbox.
// Latches the word written on select 0 and keeps sel[5:3] as a level
// that the MCU polls on port 3.

`timescale 1ns/10ps

module cop_main_port
    import cop_pkg::*;
(
    input  logic                  clk24,
    input  logic                  rst24,
    input  main_wr_t              main_wr,
    output logic [MCU_WORD_W-1:0] mail_word,
    output logic                  mail_pulse,
    output logic [2:0]            sel_hi
);

    logic mail_wr;

    // Write cycle aimed at the mailbox
    assign mail_wr = main_wr.we && main_wr.sel[0];

    // Mailbox word and its event pulse
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            mail_word  <= '0;
            mail_pulse <= 1'b0;
        end else begin
            mail_pulse <= mail_wr;
            if (mail_wr) begin
                mail_word <= main_wr.data;
            end
        end
    end

    // Upper selects follow the bus every cycle
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            sel_hi <= 3'b000;
        end else begin
            sel_hi <= main_wr.sel[5:3];
        end
    end

endmodule

/* design/cop_mcu_bridge.sv */
// MCU side of the mailbox.
// Raises the mail interrupt, serves mail bytes on port 0 and builds the
// reply word from port 0 writes. Strobes come in on p2 as the MCU drives
// them, all active low.

`timescale 1ns/10ps

module cop_mcu_bridge
    import cop_pkg::*;
(
    input  logic                  clk24,
    input  logic                  rst24,
    input  mcu_ports_t            mcu_ports,
    input  logic [MCU_WORD_W-1:0] mail_word,
    input  logic                  mail_pulse,
    output logic                  mcu_intn,
    output logic [MCU_PORT_W-1:0] p0_in,
    output logic [MCU_WORD_W-1:0] reply_word
);

    localparam int HALF = MCU_WORD_W / 2;

    irq_state_e irq_state;
    mcu_xfer_e  xfer;
    logic       ack;

    // Interrupt acknowledge from the MCU
    assign ack = ~mcu_ports.p2[3];

    // Only a single low strobe is a valid transfer
    always_comb begin
        case (mcu_ports.p2[7:4])
            4'b1110: xfer = XFER_RD_HI;
            4'b1101: xfer = XFER_RD_LO;
            4'b1011: xfer = XFER_WR_LO;
            4'b0111: xfer = XFER_WR_HI;
            default: xfer = XFER_NONE;
        endcase
    end

    // Acknowledge wins over a mail pulse in the same cycle
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            irq_state <= IRQ_IDLE;
        end else if (ack) begin
            irq_state <= IRQ_IDLE;
        end else if (mail_pulse) begin
            irq_state <= IRQ_PENDING;
        end
    end

    assign mcu_intn = (irq_state != IRQ_PENDING);

    // Port 0 read path holds until the next read strobe
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            p0_in <= '0;
        end else begin
            case (xfer)
                XFER_RD_HI: p0_in <= mail_word[MCU_WORD_W-1:HALF];
                XFER_RD_LO: p0_in <= mail_word[HALF-1:0];
                default:    p0_in <= p0_in;
            endcase
        end
    end

    // Reply assembled one byte at a time
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            reply_word <= '0;
        end else begin
            case (xfer)
                XFER_WR_HI: reply_word[MCU_WORD_W-1:HALF] <= mcu_ports.p0;
                XFER_WR_LO: reply_word[HALF-1:0]          <= mcu_ports.p0;
                default:    reply_word                    <= reply_word;
            endcase
        end
    end

    // Interrupt is only released by the MCU
    a_intn_rise_on_ack: assert property (
        @(posedge clk24) disable iff (rst24)
        $rose(mcu_intn) |-> $past(ack)
    ) else $error("cop_mcu_bridge: mcu_intn released without acknowledge");

    // MCU firmware drives one port strobe at a time
    a_one_strobe: assert property (
        @(posedge clk24) disable iff (rst24)
        $countones(~mcu_ports.p2[7:4]) <= 1
    ) else $error("cop_mcu_bridge: more than one p2 strobe low");

endmodule

/* design/cop_bank_out.sv */
// Bank flag register fed by MCU ports 1 and 3.
// Gives the memory side a stable copy of the flags and a pulse on
// every change.

`timescale 1ns/10ps

module cop_bank_out
    import cop_pkg::*;
(
    input  logic        clk24,
    input  logic        rst24,
    input  mcu_ports_t  mcu_ports,
    output bank_flags_t bank_flags,
    output logic        bank_change
);

    bank_flags_t next_flags;

    // Port to flag mapping
    always_comb begin
        next_flags.sndflag = mcu_ports.p1[6:5];
        next_flags.b1flg   = mcu_ports.p1[4:3];
        next_flags.b0flg   = mcu_ports.p1[2];
        next_flags.mixflg  = mcu_ports.p1[1:0];
        next_flags.crback  = mcu_ports.p3[2:0];
    end

    // Change pulse lines up with the new value
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            bank_flags  <= '0;
            bank_change <= 1'b0;
        end else begin
            bank_flags  <= next_flags;
            bank_change <= (next_flags != bank_flags);
        end
    end

endmodule

/* design/cop_mcu_sub.sv */
// Top of the 24 MHz protection MCU glue.
// The MCU core sits outside and its ports come in as mcu_ports.
// p3_in, p0_in and mcu_intn go back to the MCU inputs.

`timescale 1ns/10ps

module cop_mcu_sub
    import cop_pkg::*;
#(
    parameter int MCU_DIV = 3
) (
    input  logic                  clk24,
    input  logic                  rst24,
    input  main_wr_t              main_wr,
    input  mcu_ports_t            mcu_ports,
    output logic [MCU_PORT_W-1:0] p3_in,
    output logic                  mcu_intn,
    output logic [MCU_PORT_W-1:0] p0_in,
    output logic [MCU_WORD_W-1:0] reply_word,
    output bank_flags_t           bank_flags,
    output logic                  bank_change,
    output logic                  cen3,
    output logic                  cen1p5,
    output logic                  cen_mcu
);

    logic [MCU_WORD_W-1:0] mail_word;
    logic                  mail_pulse;
    logic [2:0]            sel_hi;

    cop_cen24 #(
        .MCU_DIV (MCU_DIV)
    ) u_cen (
        .clk24   (clk24),
        .rst24   (rst24),
        .cen3    (cen3),
        .cen1p5  (cen1p5),
        .cen_mcu (cen_mcu)
    );

    cop_main_port u_main (
        .clk24      (clk24),
        .rst24      (rst24),
        .main_wr    (main_wr),
        .mail_word  (mail_word),
        .mail_pulse (mail_pulse),
        .sel_hi     (sel_hi)
    );

    cop_mcu_bridge u_bridge (
        .clk24      (clk24),
        .rst24      (rst24),
        .mcu_ports  (mcu_ports),
        .mail_word  (mail_word),
        .mail_pulse (mail_pulse),
        .mcu_intn   (mcu_intn),
        .p0_in      (p0_in),
        .reply_word (reply_word)
    );

    cop_bank_out u_bank (
        .clk24       (clk24),
        .rst24       (rst24),
        .mcu_ports   (mcu_ports),
        .bank_flags  (bank_flags),
        .bank_change (bank_change)
    );

    // Port 3 as the MCU reads it
    assign p3_in = {sel_hi, mcu_ports.p3[4:0]};

    // CPU mail write reaches the MCU interrupt two cycles later
    a_mail_to_intn: assert property (
        @(posedge clk24) disable iff (rst24)
        $past(main_wr.we && main_wr.sel[0]) && mcu_ports.p2[3] |=> !mcu_intn
    ) else $error("cop_mcu_sub: mail write did not raise the MCU interrupt");

endmodule

/* verif/cop_mcu_sub_tb.sv */
// Testbench for the protection MCU glue top level.
// Concurrent assertions below do the checking. The initial block walks the
// DUT through each behavior and prints one line per test.

`timescale 1ns/10ps

module cop_mcu_sub_tb
    import cop_pkg::*;
();

    localparam int MCU_DIV = 3;
    // Tests need a few hundred cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYC = 4000;

    logic        clk24;
    logic        rst24;
    main_wr_t    main_wr;
    mcu_ports_t  mcu_ports;
    logic [7:0]  p3_in;
    logic        mcu_intn;
    logic [7:0]  p0_in;
    logic [15:0] reply_word;
    bank_flags_t bank_flags;
    logic        bank_change;
    logic        cen3;
    logic        cen1p5;
    logic        cen_mcu;

    int          cycle_cnt = 0;
    int          error_cnt = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          test_err_base = 0;
    logic [31:0] rng_state;
    logic [15:0] last_mail;
    logic [15:0] exp_reply;
    int          gap3;
    int          gap1p5;
    int          gap_mcu;
    logic        seen3;
    logic        seen1p5;
    logic        seen_mcu;
    logic        mail_wr;
    logic        rd_hi;
    logic        rd_lo;
    logic        wr_hi;
    logic        wr_lo;
    bank_flags_t exp_flags;

    cop_mcu_sub #(
        .MCU_DIV (MCU_DIV)
    ) u_dut (
        .clk24       (clk24),
        .rst24       (rst24),
        .main_wr     (main_wr),
        .mcu_ports   (mcu_ports),
        .p3_in       (p3_in),
        .mcu_intn    (mcu_intn),
        .p0_in       (p0_in),
        .reply_word  (reply_word),
        .bank_flags  (bank_flags),
        .bank_change (bank_change),
        .cen3        (cen3),
        .cen1p5      (cen1p5),
        .cen_mcu     (cen_mcu)
    );

    initial begin
        clk24 = 1'b0;
        forever begin
            #20 clk24 = ~clk24;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bank flags as the MCU ports define them
    function automatic bank_flags_t flags_from_ports(input logic [7:0] p1,
                                                     input logic [7:0] p3);
        bank_flags_t f;
        f.sndflag = p1[6:5];
        f.b1flg   = p1[4:3];
        f.b0flg   = p1[2];
        f.mixflg  = p1[1:0];
        f.crback  = p3[2:0];
        return f;
    endfunction

    // Strobes on p2[7:4] are active low, one at a time
    assign mail_wr   = main_wr.we && main_wr.sel[0];
    assign rd_hi     = (mcu_ports.p2[7:4] == 4'b1110);
    assign rd_lo     = (mcu_ports.p2[7:4] == 4'b1101);
    assign wr_lo     = (mcu_ports.p2[7:4] == 4'b1011);
    assign wr_hi     = (mcu_ports.p2[7:4] == 4'b0111);
    assign exp_flags = flags_from_ports(mcu_ports.p1, mcu_ports.p3);

    // Cycles since the last pulse of each enable, the last mail word
    // and the reply word built from the port 0 writes
    always @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            gap3      <= 0;
            gap1p5    <= 0;
            gap_mcu   <= 0;
            seen3     <= 1'b0;
            seen1p5   <= 1'b0;
            seen_mcu  <= 1'b0;
            last_mail <= '0;
            exp_reply <= '0;
        end else begin
            gap3     <= cen3 ? 1 : gap3 + 1;
            gap1p5   <= cen1p5 ? 1 : gap1p5 + 1;
            gap_mcu  <= cen_mcu ? 1 : gap_mcu + 1;
            seen3    <= seen3 | cen3;
            seen1p5  <= seen1p5 | cen1p5;
            seen_mcu <= seen_mcu | cen_mcu;
            if (mail_wr) begin
                last_mail <= main_wr.data;
            end
            if (wr_hi) begin
                exp_reply[15:8] <= mcu_ports.p0;
            end
            if (wr_lo) begin
                exp_reply[7:0] <= mcu_ports.p0;
            end
        end
    end

    always @(posedge clk24) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic log_error(input string msg);
        error_cnt++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    a_reset_vals: assert property (@(posedge clk24)
        rst24 |-> (mcu_intn && !u_dut.mail_pulse && !bank_change && !cen3 && !cen1p5
                   && !cen_mcu && p0_in == 8'h00 && reply_word == 16'h0000
                   && u_dut.mail_word == 16'h0000 && bank_flags == '0)
    ) else log_error("output not at its reset value");

    a_cen3_period: assert property (@(posedge clk24) disable iff (rst24)
        (cen3 && seen3) |-> gap3 == 8
    ) else log_error("cen3 period is not 8 cycles");

    a_cen1p5_period: assert property (@(posedge clk24) disable iff (rst24)
        (cen1p5 && seen1p5) |-> gap1p5 == 16
    ) else log_error("cen1p5 period is not 16 cycles");

    a_cen_mcu_period: assert property (@(posedge clk24) disable iff (rst24)
        (cen_mcu && seen_mcu) |-> gap_mcu == MCU_DIV
    ) else log_error("cen_mcu period differs from MCU_DIV");

    a_intn_fall: assert property (@(posedge clk24) disable iff (rst24)
        $past(mail_wr) && mcu_ports.p2[3] |=> !mcu_intn
    ) else log_error("mcu_intn not low 2 cycles after mail write");

    a_intn_ack: assert property (@(posedge clk24) disable iff (rst24)
        !mcu_ports.p2[3] |=> mcu_intn
    ) else log_error("mcu_intn not high after acknowledge");

    a_intn_fall_src: assert property (@(posedge clk24) disable iff (rst24)
        $fell(mcu_intn) |-> $past(mail_wr, 2)
    ) else log_error("mcu_intn fell without a select 0 write");

    a_rd_hi: assert property (@(posedge clk24) disable iff (rst24)
        rd_hi |=> p0_in == $past(last_mail[15:8])
    ) else log_error("p0_in is not the mail high byte");

    a_rd_lo: assert property (@(posedge clk24) disable iff (rst24)
        rd_lo |=> p0_in == $past(last_mail[7:0])
    ) else log_error("p0_in is not the mail low byte");

    a_p0_hold: assert property (@(posedge clk24) disable iff (rst24)
        !(rd_hi || rd_lo) |=> $stable(p0_in)
    ) else log_error("p0_in changed without a read strobe");

    a_reply: assert property (@(posedge clk24) disable iff (rst24)
        reply_word == exp_reply
    ) else log_error("reply_word does not match the bytes written on port 0");

    a_flags: assert property (@(posedge clk24) disable iff (rst24)
        1'b1 |=> bank_flags == $past(exp_flags)
    ) else log_error("bank_flags do not match ports 1 and 3");

    a_change: assert property (@(posedge clk24) disable iff (rst24)
        bank_change == ($past(exp_flags) != $past(exp_flags, 2))
    ) else log_error("bank_change does not match a flag change");

    a_p3_in: assert property (@(posedge clk24) disable iff (rst24)
        1'b1 |=> p3_in == {$past(main_wr.sel[5:3]), mcu_ports.p3[4:0]}
    ) else log_error("p3_in does not carry sel[5:3] and p3[4:0]");

    // Inputs change 2 ns after the edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk24);
        #2;
    endtask

    task automatic cpu_write(input logic [5:0] sel, input logic [15:0] data);
        main_wr.sel  = sel;
        main_wr.we   = 1'b1;
        main_wr.data = data;
        wait_cycles(1);
        main_wr.we = 1'b0;
    endtask

    task automatic pulse_p2(input logic [7:0] pattern);
        mcu_ports.p2 = pattern;
        wait_cycles(1);
        mcu_ports.p2 = 8'hff;
    endtask

    task automatic test_start();
        test_err_base = error_cnt;
    endtask

    task automatic test_finish(input string name);
        if (error_cnt == test_err_base) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check errors", name, error_cnt - test_err_base);
        end
    endtask

    initial begin
        logic [7:0] a_byte;
        logic [7:0] b_byte;
        rst24        = 1'b1;
        main_wr      = '0;
        mcu_ports.p0 = 8'h00;
        mcu_ports.p1 = 8'h00;
        mcu_ports.p2 = 8'hff;
        mcu_ports.p3 = 8'h00;
        rng_state    = 32'd56254;

        test_start();
        wait_cycles(16);
        rst24 = 1'b0;
        wait_cycles(40);
        test_finish("reset and enables");

        test_start();
        cpu_write(6'b000001, 16'h1234);
        wait_cycles(3);
        // Ack and a new mail write in the same cycle
        mcu_ports.p2 = 8'hf7;
        cpu_write(6'b000001, 16'h5678);
        mcu_ports.p2 = 8'hff;
        wait_cycles(3);
        // Mail pulse meets the ack
        cpu_write(6'b000001, 16'h9abc);
        pulse_p2(8'hf7);
        wait_cycles(3);
        cpu_write(6'b000010, 16'hdef0);
        wait_cycles(4);
        test_finish("mail interrupt");

        test_start();
        repeat (8) begin
            rng_state = next_random(rng_state);
            cpu_write(6'b000001, rng_state[15:0]);
            wait_cycles(2);
            pulse_p2(8'hef);
            pulse_p2(8'hdf);
            pulse_p2(8'hf7);
            wait_cycles(2);
        end
        test_finish("port 0 reads");

        test_start();
        repeat (8) begin
            rng_state = next_random(rng_state);
            a_byte = rng_state[7:0];
            b_byte = rng_state[15:8];
            mcu_ports.p0 = a_byte;
            pulse_p2(8'h7f);
            mcu_ports.p0 = b_byte;
            pulse_p2(8'hbf);
            mcu_ports.p0 = rng_state[23:16];
            wait_cycles(2);
        end
        test_finish("reply word");

        test_start();
        repeat (12) begin
            rng_state = next_random(rng_state);
            mcu_ports.p1 = rng_state[7:0];
            mcu_ports.p3 = rng_state[15:8];
            cpu_write({rng_state[18:16], 3'b000}, rng_state[31:16]);
            // Same pattern again, then only unmapped bits
            mcu_ports.p1 = rng_state[7:0];
            wait_cycles(2);
            mcu_ports.p1[7]   = ~mcu_ports.p1[7];
            mcu_ports.p3[7:3] = ~mcu_ports.p3[7:3];
            wait_cycles(2);
        end
        test_finish("bank flags");

        wait_cycles(4);
        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, error_cnt);
        if (tests_failed == 0 && error_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* cop_mcu_sub.f */
design/cop_pkg.sv
design/cop_cen24.sv
design/cop_main_port.sv
design/cop_mcu_bridge.sv
design/cop_bank_out.sv
design/cop_mcu_sub.sv
verif/cop_mcu_sub_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module cop_mcu_sub_tb \
        -f cop_mcu_sub.f \
        -Mdir "$OBJ" -o sim_model; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_model" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    echo "Failure found in $LOG"
    exit 1
fi

if ! grep -q "Regression passed" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi

exit 0
